//--- verilog/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Datapath and address width
`define WORD_BITS 32

// Register file shape
`define REG_COUNT 16
`define REG_BITS 4 // Enough to index REG_COUNT

// Instruction sizes in bytes
`define SHORT_INSTR_BYTES 4 // Opcode word only
`define LONG_INSTR_BYTES 8  // Opcode word plus constant word

// Stack grows upward, one word per push
`define STACK_STEP 4

// Registers with a fixed role
`define SP_REG 0       // Stack pointer
`define FLAG_REG 1     // Compare flags
`define CODE_SEG_REG 2 // Added to every fetch address

`endif

//--- verilog/cpu_pkg.sv
`include "cpu_consts.svh"

package cpu_pkg;

  // Bit 7 set marks an opcode followed by a constant word
  typedef enum logic [7:0] {
    MovRR    = 8'h01,
    MovRdR   = 8'h02,
    PushR    = 8'h03,
    PopR     = 8'h04,
    CallR    = 8'h05,
    Ret      = 8'h06,
    AddRRR   = 8'h07,
    SubRRR   = 8'h08,
    IncR     = 8'h09,
    DecR     = 8'h0a,
    ShlRRR   = 8'h0b,
    ShrRRR   = 8'h0c,
    CmpRR    = 8'h0d,
    CmpLtRRR = 8'h0e,
    DoutR    = 8'h0f,
    Stall    = 8'h10,
    MovRC    = 8'h80, // Long forms from here on
    MovRdC   = 8'h81,
    MovdCR   = 8'h82,
    AddRRC   = 8'h83,
    JmpC     = 8'h84,
    JeC      = 8'h85,
    JneC     = 8'h86,
    JzRC     = 8'h87
  } opcode_t;

  // Decoded instruction from fetch
  typedef struct packed {
    opcode_t               opcode;
    logic [`REG_BITS-1:0]  dst;
    logic [`REG_BITS-1:0]  srcA;
    logic [`REG_BITS-1:0]  srcB;
    logic [`WORD_BITS-1:0] constant; // Second word, zero for short forms
    logic [`WORD_BITS-1:0] pointer;  // Address of this instruction
  } instr_t;

  // Instruction plus register values
  typedef struct packed {
    instr_t                instr;
    logic [`WORD_BITS-1:0] dstValue;
    logic [`WORD_BITS-1:0] srcAValue;
    logic [`WORD_BITS-1:0] srcBValue;
  } operands_t;

  // One RAM bus request
  typedef struct packed {
    logic                  read;
    logic                  write;
    logic [`WORD_BITS-1:0] address;
    logic [`WORD_BITS-1:0] writeData;
  } memReq_t;

  typedef struct packed {
    operands_t             operands;
    logic [`WORD_BITS-1:0] loaded; // Word returned by a data read
  } exec_t;

  typedef struct packed {
    logic                  enable;
    logic [`REG_BITS-1:0]  index;
    logic [`WORD_BITS-1:0] value;
  } regWrite_t;

endpackage

//--- verilog/fetchStage.sv
`include "cpu_consts.svh"

module fetchStage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`WORD_BITS-1:0] ramIn,
  input  logic                  retire,
  input  logic [`WORD_BITS-1:0] nextPointer,
  input  logic [`WORD_BITS-1:0] codeSegment,
  output cpu_pkg::memReq_t      fetchReq,
  output cpu_pkg::instr_t       instr,
  output logic                  decodeDone,
  output logic [`WORD_BITS-1:0] instrPointer
);

  typedef enum logic [2:0] {
    FetchBoot,   // Leaving reset
    FetchReq,    // First fetch only
    FetchWait,   // RAM latching address
    FetchDecode, // Opcode word on ramIn
    ConstWait,
    ConstDecode, // Constant word on ramIn
    FetchBusy    // Instruction in later stages
  } state_t;

  state_t                state;
  logic [`WORD_BITS-1:0] pointer;
  cpu_pkg::opcode_t      decodedOp;
  logic                  hasConst;
  logic [`REG_BITS-1:0]  srcAField;
  logic [`REG_BITS-1:0]  srcBField;

  assign decodedOp    = cpu_pkg::opcode_t'(ramIn[7:0]);
  assign hasConst     = ramIn[7]; // Long form marker
  assign instrPointer = pointer;

  // Implicit operands steered into unused fields
  always_comb begin
    srcAField = ramIn[16 +: `REG_BITS];
    srcBField = ramIn[24 +: `REG_BITS];
    case (decodedOp)
      cpu_pkg::JeC, cpu_pkg::JneC: srcAField = `REG_BITS'(`FLAG_REG); // Flags for exec
      cpu_pkg::PushR, cpu_pkg::PopR, cpu_pkg::CallR, cpu_pkg::Ret:
        srcBField = `REG_BITS'(`SP_REG); // Stack pointer for address
      default: ;
    endcase
  end

  // Requests are combinational so a retire starts the next fetch at once
  always_comb begin
    fetchReq = '0;
    case (state)
      FetchReq: begin
        fetchReq.read    = 1'b1;
        fetchReq.address = codeSegment + pointer;
      end
      FetchDecode: begin
        fetchReq.read    = hasConst; // Constant word right behind the opcode
        fetchReq.address = codeSegment + pointer + `WORD_BITS'(`SHORT_INSTR_BYTES);
      end
      FetchBusy: begin
        fetchReq.read    = retire;
        fetchReq.address = codeSegment + nextPointer;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= FetchBoot;
      pointer    <= '0;
      decodeDone <= 1'b0;
    end else begin
      decodeDone <= 1'b0; // One-cycle pulse
      case (state)
        FetchBoot: state <= FetchReq;
        FetchReq:  state <= FetchWait;
        FetchWait: state <= FetchDecode;
        FetchDecode: begin
          if (hasConst) begin
            state <= ConstWait;
          end else begin
            state      <= FetchBusy;
            decodeDone <= 1'b1;
          end
        end
        ConstWait: state <= ConstDecode;
        ConstDecode: begin
          state      <= FetchBusy;
          decodeDone <= 1'b1;
        end
        FetchBusy: begin
          if (retire) begin
            state   <= FetchWait; // Request already on the bus
            pointer <= nextPointer;
          end
        end
        default: state <= FetchBoot;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == FetchDecode) begin
      instr.opcode   <= decodedOp;
      instr.dst      <= ramIn[8 +: `REG_BITS];
      instr.srcA     <= srcAField;
      instr.srcB     <= srcBField;
      instr.constant <= '0;
      instr.pointer  <= pointer;
    end
    if (state == ConstDecode) instr.constant <= ramIn;
  end

endmodule

//--- verilog/regFile.sv
`include "cpu_consts.svh"

module regFile (
  input  logic                  clk,
  input  logic                  reset,
  input  cpu_pkg::instr_t       instr,
  input  logic                  decodeDone,
  input  cpu_pkg::regWrite_t    wb,
  input  logic                  spInc,
  input  logic                  spDec,
  input  logic                  flagsWrite,
  input  logic [2:0]            flags,
  output cpu_pkg::operands_t    operands,
  output logic                  operandsReady,
  output logic [`WORD_BITS-1:0] codeSegment
);

  logic [`WORD_BITS-1:0] regs [`REG_COUNT];

  // Write-back, stack step and flags all land on the retire edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      operandsReady <= 1'b0;
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else begin
      operandsReady <= decodeDone;
      if (wb.enable) regs[wb.index] <= wb.value;
      if (spInc) begin
        regs[`SP_REG] <= regs[`SP_REG] + `WORD_BITS'(`STACK_STEP); // Push, call
      end else if (spDec) begin
        regs[`SP_REG] <= regs[`SP_REG] - `WORD_BITS'(`STACK_STEP); // Pop, ret
      end
      if (flagsWrite) regs[`FLAG_REG] <= {{(`WORD_BITS-3){1'b0}}, flags};
    end
  end

  // Operand capture one cycle after decode
  always_ff @(posedge clk) begin
    if (decodeDone) begin
      operands.instr     <= instr;
      operands.dstValue  <= regs[instr.dst];
      operands.srcAValue <= regs[instr.srcA];
      operands.srcBValue <= regs[instr.srcB];
    end
  end

  // Forward a segment write so the fetch in the retire cycle sees it
  assign codeSegment = (wb.enable && wb.index == `REG_BITS'(`CODE_SEG_REG)) ?
                       wb.value : regs[`CODE_SEG_REG];

endmodule

//--- verilog/memStage.sv
`include "cpu_consts.svh"

module memStage (
  input  logic                  clk,
  input  logic                  reset,
  input  cpu_pkg::memReq_t      fetchReq,
  input  cpu_pkg::operands_t    operands,
  input  logic                  operandsReady,
  input  logic [`WORD_BITS-1:0] ramIn,
  output logic [`WORD_BITS-1:0] ramAddress,
  output logic [`WORD_BITS-1:0] ramOut,
  output logic                  readReq,
  output logic                  writeReq,
  output cpu_pkg::exec_t        execIn,
  output logic                  memDone
);

  typedef enum logic [1:0] {
    MemIdle,
    MemWait,    // RAM latching address
    MemComplete // Read data on ramIn
  } state_t;

  state_t                state;
  cpu_pkg::memReq_t      dataReq;
  cpu_pkg::memReq_t      busReq;
  logic                  isMem;
  logic                  dataActive;
  logic                  accessDone;
  logic [`WORD_BITS-1:0] loaded;

  // Data address and direction per opcode
  always_comb begin
    dataReq = '0;
    case (operands.instr.opcode)
      cpu_pkg::MovRdC: begin
        dataReq.read    = 1'b1;
        dataReq.address = operands.instr.constant;
      end
      cpu_pkg::MovRdR: begin
        dataReq.read    = 1'b1;
        dataReq.address = operands.srcAValue;
      end
      cpu_pkg::MovdCR: begin
        dataReq.write     = 1'b1;
        dataReq.address   = operands.instr.constant;
        dataReq.writeData = operands.srcAValue;
      end
      cpu_pkg::PushR: begin
        dataReq.write     = 1'b1;
        dataReq.address   = operands.srcBValue; // Stack pointer via srcB
        dataReq.writeData = operands.dstValue;
      end
      cpu_pkg::CallR: begin
        dataReq.write     = 1'b1;
        dataReq.address   = operands.srcBValue;
        dataReq.writeData = operands.instr.pointer; // Return base, ret adds 4
      end
      cpu_pkg::PopR, cpu_pkg::Ret: begin
        dataReq.read    = 1'b1;
        dataReq.address = operands.srcBValue - `WORD_BITS'(`STACK_STEP); // Top of stack
      end
      default: ;
    endcase
  end

  assign isMem      = dataReq.read || dataReq.write;
  assign dataActive = operandsReady && isMem; // Fetch is idle in this cycle
  assign busReq     = dataActive ? dataReq : fetchReq;

  assign ramAddress = busReq.address;
  assign ramOut     = busReq.writeData;
  assign readReq    = busReq.read;
  assign writeReq   = busReq.write;

  // Non-memory opcodes go straight through
  assign memDone = (operandsReady && !isMem) || accessDone;
  assign execIn  = '{operands: operands, loaded: loaded};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= MemIdle;
      accessDone <= 1'b0;
    end else begin
      accessDone <= (state == MemComplete);
      case (state)
        MemIdle:     if (dataActive) state <= MemWait;
        MemWait:     state <= MemComplete;
        MemComplete: state <= MemIdle;
        default:     state <= MemIdle;
      endcase
    end
  end

  // Writes capture a don't-care word here, exec ignores it
  always_ff @(posedge clk) begin
    if (state == MemComplete) loaded <= ramIn;
  end

endmodule

//--- verilog/execStage.sv
`include "cpu_consts.svh"

module execStage (
  input  logic                  clk,
  input  logic                  reset,
  input  cpu_pkg::exec_t        execIn,
  input  logic                  memDone,
  output cpu_pkg::regWrite_t    wb,
  output logic                  spInc,
  output logic                  spDec,
  output logic                  flagsWrite,
  output logic [2:0]            flags,
  output logic [`WORD_BITS-1:0] nextPointer,
  output logic                  retire,
  output logic [`WORD_BITS-1:0] doutValue,
  output logic                  doutStrobe
);

  cpu_pkg::operands_t    ops;
  logic                  writeEnable;
  logic [`WORD_BITS-1:0] result;
  logic                  stepUp;
  logic                  stepDown;
  logic                  setFlags;
  logic [2:0]            cmpFlags;
  logic                  jumpTaken;
  logic [`WORD_BITS-1:0] stepPointer;
  logic [`WORD_BITS-1:0] nextValue;

  assign ops = execIn.operands;

  // Equal, less, greater of dst against srcA
  assign cmpFlags = {ops.dstValue > ops.srcAValue,
                     ops.dstValue < ops.srcAValue,
                     ops.dstValue == ops.srcAValue};

  always_comb begin
    writeEnable = 1'b0;
    result      = '0;
    stepUp      = 1'b0;
    stepDown    = 1'b0;
    setFlags    = 1'b0;
    jumpTaken   = 1'b0;
    stepPointer = ops.instr.pointer + (ops.instr.opcode[7] ?
                  `WORD_BITS'(`LONG_INSTR_BYTES) : `WORD_BITS'(`SHORT_INSTR_BYTES));
    nextValue   = stepPointer;
    case (ops.instr.opcode)
      cpu_pkg::MovRC: begin
        writeEnable = 1'b1;
        result      = ops.instr.constant;
      end
      cpu_pkg::MovRR: begin
        writeEnable = 1'b1;
        result      = ops.srcAValue;
      end
      cpu_pkg::MovRdC, cpu_pkg::MovRdR: begin
        writeEnable = 1'b1;
        result      = execIn.loaded;
      end
      cpu_pkg::PushR: stepUp = 1'b1; // Data already written by mem stage
      cpu_pkg::PopR: begin
        writeEnable = 1'b1;
        result      = execIn.loaded;
        stepDown    = 1'b1;
      end
      cpu_pkg::CallR: begin
        stepUp    = 1'b1;
        nextValue = ops.dstValue; // Target held in dst
      end
      cpu_pkg::Ret: begin
        stepDown  = 1'b1;
        nextValue = execIn.loaded + `WORD_BITS'(`SHORT_INSTR_BYTES); // Skip the call
      end
      cpu_pkg::AddRRR: begin
        writeEnable = 1'b1;
        result      = ops.srcAValue + ops.srcBValue;
      end
      cpu_pkg::AddRRC: begin
        writeEnable = 1'b1;
        result      = ops.srcAValue + ops.instr.constant;
      end
      cpu_pkg::SubRRR: begin
        writeEnable = 1'b1;
        result      = ops.srcAValue - ops.srcBValue;
      end
      cpu_pkg::IncR: begin
        writeEnable = 1'b1;
        result      = ops.dstValue + 1'b1;
      end
      cpu_pkg::DecR: begin
        writeEnable = 1'b1;
        result      = ops.dstValue - 1'b1;
      end
      cpu_pkg::ShlRRR: begin
        writeEnable = 1'b1;
        result      = ops.srcAValue << ops.srcBValue;
      end
      cpu_pkg::ShrRRR: begin
        writeEnable = 1'b1;
        result      = ops.srcAValue >> ops.srcBValue; // Logical
      end
      cpu_pkg::CmpRR: setFlags = 1'b1;
      cpu_pkg::CmpLtRRR: begin
        writeEnable = 1'b1;
        result      = {{(`WORD_BITS-1){1'b0}}, ops.srcAValue < ops.srcBValue};
      end
      cpu_pkg::JmpC: jumpTaken = 1'b1;
      cpu_pkg::JeC:  jumpTaken = ops.srcAValue[0];  // srcA steered to flags
      cpu_pkg::JneC: jumpTaken = !ops.srcAValue[0];
      cpu_pkg::JzRC: jumpTaken = (ops.srcBValue == '0); // Tested register in srcB
      cpu_pkg::Stall: nextValue = ops.instr.pointer; // Spin in place
      default: ;
    endcase
    if (jumpTaken) nextValue = ops.instr.constant;
  end

  // Everything registered so retire and write-back share one edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb          <= '0;
      spInc       <= 1'b0;
      spDec       <= 1'b0;
      flagsWrite  <= 1'b0;
      flags       <= '0;
      nextPointer <= '0;
      retire      <= 1'b0;
      doutValue   <= '0;
      doutStrobe  <= 1'b0;
    end else begin
      retire     <= memDone;
      wb.enable  <= memDone && writeEnable;
      spInc      <= memDone && stepUp;
      spDec      <= memDone && stepDown;
      flagsWrite <= memDone && setFlags;
      doutStrobe <= memDone && (ops.instr.opcode == cpu_pkg::DoutR);
      if (memDone) begin
        wb.index    <= ops.instr.dst;
        wb.value    <= result;
        flags       <= cmpFlags;
        nextPointer <= nextValue;
        if (ops.instr.opcode == cpu_pkg::DoutR) doutValue <= ops.dstValue;
      end
    end
  end

endmodule

//--- verilog/cpuCore.sv
`include "cpu_consts.svh"

module cpuCore (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`WORD_BITS-1:0] ramIn,
  output logic [`WORD_BITS-1:0] ramAddress,
  output logic [`WORD_BITS-1:0] ramOut,
  output logic                  readReq,
  output logic                  writeReq,
  output logic [`WORD_BITS-1:0] doutValue,
  output logic                  doutStrobe,
  output logic [`WORD_BITS-1:0] instrPointer
);

  cpu_pkg::memReq_t      fetchReq;
  cpu_pkg::instr_t       instr;
  logic                  decodeDone;
  cpu_pkg::operands_t    operands;
  logic                  operandsReady;
  cpu_pkg::exec_t        execIn;
  logic                  memDone;
  cpu_pkg::regWrite_t    wb;
  logic                  spInc;
  logic                  spDec;
  logic                  flagsWrite;
  logic [2:0]            flags;
  logic [`WORD_BITS-1:0] codeSegment;
  logic [`WORD_BITS-1:0] nextPointer;
  logic                  retire;

  fetchStage fetch (
    .clk(clk), .reset(reset), .ramIn(ramIn), .retire(retire),
    .nextPointer(nextPointer), .codeSegment(codeSegment), .fetchReq(fetchReq),
    .instr(instr), .decodeDone(decodeDone), .instrPointer(instrPointer)
  );

  regFile regs (
    .clk(clk), .reset(reset), .instr(instr), .decodeDone(decodeDone), .wb(wb),
    .spInc(spInc), .spDec(spDec), .flagsWrite(flagsWrite), .flags(flags),
    .operands(operands), .operandsReady(operandsReady), .codeSegment(codeSegment)
  );

  // Sole owner of the RAM port
  memStage mem (
    .clk(clk), .reset(reset), .fetchReq(fetchReq), .operands(operands),
    .operandsReady(operandsReady), .ramIn(ramIn), .ramAddress(ramAddress),
    .ramOut(ramOut), .readReq(readReq), .writeReq(writeReq), .execIn(execIn),
    .memDone(memDone)
  );

  execStage exec (
    .clk(clk), .reset(reset), .execIn(execIn), .memDone(memDone), .wb(wb),
    .spInc(spInc), .spDec(spDec), .flagsWrite(flagsWrite), .flags(flags),
    .nextPointer(nextPointer), .retire(retire), .doutValue(doutValue),
    .doutStrobe(doutStrobe)
  );

endmodule

//--- test/cpuCore_assert.sv
module cpuCore_assert (
  input logic clk,
  input logic reset,
  input logic readReq,
  input logic writeReq,
  input logic doutStrobe
);
  timeunit 1ns;
  timeprecision 1ps;

  // RAM bus carries one request per cycle
  exclusiveStrobes: assert property (@(posedge clk) disable iff (reset)
    !(readReq && writeReq))
    else $error("readReq and writeReq high in the same cycle");

  readPulse: assert property (@(posedge clk) disable iff (reset)
    readReq |=> !readReq)
    else $error("readReq held longer than one cycle");

  writePulse: assert property (@(posedge clk) disable iff (reset)
    writeReq |=> !writeReq)
    else $error("writeReq held longer than one cycle");

  // Bus stays quiet while reset is high
  quietInReset: assert property (@(posedge clk)
    reset |-> (!readReq && !writeReq))
    else $error("RAM request issued during reset");

  doutPulse: assert property (@(posedge clk) disable iff (reset)
    doutStrobe |=> !doutStrobe)
    else $error("doutStrobe held longer than one cycle");

endmodule

bind cpuCore cpuCore_assert protocolChecks (
  .clk(clk), .reset(reset), .readReq(readReq), .writeReq(writeReq),
  .doutStrobe(doutStrobe)
);

//--- test/cpuCore_tb.sv
`include "cpu_consts.svh"

module cpuCore_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // One expected RAM transfer
  typedef struct packed {
    logic [31:0] cycle;   // Edge count when the strobe is sampled
    logic        write;
    logic [31:0] address;
    logic [31:0] data;    // Only checked for writes
  } busEvent_t;

  localparam int clockPeriod = 20;
  localparam int ramWords    = 4096; // 16 KB covering byte address bits 13:2

  logic        clk   = 1'b0;
  logic        reset = 1'b1;
  logic [31:0] ramIn = '0;
  logic [31:0] ramAddress;
  logic [31:0] ramOut;
  logic        readReq;
  logic        writeReq;
  logic [31:0] doutValue;
  logic        doutStrobe;
  logic [31:0] instrPointer;

  logic [31:0] ramWord [ramWords];
  logic [31:0] modelRegs [`REG_COUNT]; // Reference register file
  logic [31:0] modelData [logic [31:0]]; // Reference data memory
  logic [31:0] modelPc;
  logic [31:0] busCycle; // Expected edge of the next fetch
  busEvent_t   busQueue [$];
  logic [31:0] doutQueue [$];
  logic [31:0] pointerQueue [$]; // Address of each executed DoutR
  logic [31:0] lfsrState;
  logic [31:0] edgeCount = '0;
  int          instrCount = 0;
  logic        programBuilt = 1'b0;
  logic        sampledRead = 1'b0;
  logic        sampledWrite = 1'b0;
  logic [31:0] sampledAddr = '0;
  logic [31:0] sampledData = '0;
  logic        pendingRead = 1'b0;
  logic [31:0] pendingAddr = '0;

  cpuCore uut (
    .clk(clk), .reset(reset), .ramIn(ramIn), .ramAddress(ramAddress), .ramOut(ramOut),
    .readReq(readReq), .writeReq(writeReq), .doutValue(doutValue),
    .doutStrobe(doutStrobe), .instrPointer(instrPointer)
  );

  always #(clockPeriod / 2) clk = ~clk;

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    abortRun($sformatf("ERROR at %0t ns: %s expected %h, got %h",
                       $time, name, expected, actual));
  endtask

  // Fibonacci taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randomBits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value     = {value[30:0], lfsrState[0]}; // One step per bit
    end
  endtask

  // Picks r3 to r14 so special registers and the r15 marker stay intact
  task automatic pickReg(output logic [3:0] r);
    logic [31:0] v;
    randomBits(4, v);
    r = 4'(3 + v % 12);
  endtask

  function automatic logic [31:0] encode(input cpu_pkg::opcode_t op, input logic [3:0] d,
                                         input logic [3:0] a, input logic [3:0] b);
    return {4'h0, b, 4'h0, a, 4'h0, d, op};
  endfunction

  task automatic queueBus(input logic [31:0] cycle, input logic write,
                          input logic [31:0] address, input logic [31:0] data);
    busEvent_t ev;
    ev.cycle   = cycle;
    ev.write   = write;
    ev.address = address;
    ev.data    = data;
    busQueue.push_back(ev);
  endtask

  // Place one instruction and run it on the reference model
  task automatic addInstr(input cpu_pkg::opcode_t op, input logic [3:0] d,
                          input logic [3:0] a, input logic [3:0] b, input logic [31:0] k);
    logic        isLong;
    logic        hasData;
    logic        isWrite;
    logic [31:0] dataAddr;
    logic [31:0] dataWord;
    logic [31:0] next;
    logic [31:0] base;
    isLong   = op[7]; // Constant word follows
    hasData  = 1'b0;
    isWrite  = 1'b0;
    dataAddr = '0;
    dataWord = '0;
    next     = modelPc + (isLong ? 32'd8 : 32'd4);
    ramWord[modelPc[13:2]] = encode(op, d, a, b);
    queueBus(busCycle, 1'b0, modelPc, '0);
    if (isLong) begin
      ramWord[modelPc[13:2] + 1] = k;
      queueBus(busCycle + 2, 1'b0, modelPc + 4, '0);
    end
    case (op)
      cpu_pkg::MovRC: modelRegs[d] = k;
      cpu_pkg::MovRR: modelRegs[d] = modelRegs[a];
      cpu_pkg::MovRdC, cpu_pkg::MovRdR: begin
        hasData      = 1'b1;
        dataAddr     = (op == cpu_pkg::MovRdC) ? k : modelRegs[a];
        modelRegs[d] = modelData[dataAddr];
      end
      cpu_pkg::MovdCR: begin
        hasData  = 1'b1;
        isWrite  = 1'b1;
        dataAddr = k;
        dataWord = modelRegs[a];
      end
      cpu_pkg::PushR, cpu_pkg::CallR: begin
        hasData  = 1'b1;
        isWrite  = 1'b1;
        dataAddr = modelRegs[`SP_REG];
        dataWord = (op == cpu_pkg::PushR) ? modelRegs[d] : modelPc; // Call saves own address
        if (op == cpu_pkg::CallR) next = modelRegs[d];
        modelRegs[`SP_REG] = modelRegs[`SP_REG] + `STACK_STEP;
      end
      cpu_pkg::PopR, cpu_pkg::Ret: begin
        hasData  = 1'b1;
        dataAddr = modelRegs[`SP_REG] - `STACK_STEP; // Top of stack
        dataWord = modelData[dataAddr];
        if (op == cpu_pkg::PopR) modelRegs[d] = dataWord;
        else next = dataWord + 4; // Resume after the call
        modelRegs[`SP_REG] = modelRegs[`SP_REG] - `STACK_STEP;
      end
      cpu_pkg::AddRRR:   modelRegs[d] = modelRegs[a] + modelRegs[b];
      cpu_pkg::AddRRC:   modelRegs[d] = modelRegs[a] + k;
      cpu_pkg::SubRRR:   modelRegs[d] = modelRegs[a] - modelRegs[b];
      cpu_pkg::IncR:     modelRegs[d] = modelRegs[d] + 1;
      cpu_pkg::DecR:     modelRegs[d] = modelRegs[d] - 1;
      cpu_pkg::ShlRRR:   modelRegs[d] = modelRegs[a] << modelRegs[b];
      cpu_pkg::ShrRRR:   modelRegs[d] = modelRegs[a] >> modelRegs[b];
      cpu_pkg::CmpRR:    modelRegs[`FLAG_REG] = {29'd0, modelRegs[d] > modelRegs[a],
                                                  modelRegs[d] < modelRegs[a],
                                                  modelRegs[d] == modelRegs[a]};
      cpu_pkg::CmpLtRRR: modelRegs[d] = {31'd0, modelRegs[a] < modelRegs[b]};
      cpu_pkg::JmpC:     next = k;
      cpu_pkg::JeC:      if (modelRegs[`FLAG_REG][0]) next = k;
      cpu_pkg::JneC:     if (!modelRegs[`FLAG_REG][0]) next = k;
      cpu_pkg::JzRC:     if (modelRegs[b] == '0) next = k;
      cpu_pkg::DoutR: begin
        doutQueue.push_back(modelRegs[d]);
        pointerQueue.push_back(modelPc); // Pointer still on DoutR when the strobe is seen
      end
      cpu_pkg::Stall:    next = modelPc;
      default: ;
    endcase
    if (isWrite) modelData[dataAddr] = dataWord;
    base = busCycle + (isLong ? 32'd2 : 32'd0);
    if (hasData) queueBus(base + 4, isWrite, dataAddr, isWrite ? dataWord : '0);
    busCycle = base + (hasData ? 32'd8 : 32'd5); // Data access adds 3 to the base 5 cycles
    modelPc  = next;
    instrCount++;
  endtask

  // Jump over one DoutR of the marker register
  task automatic condJump(input cpu_pkg::opcode_t op, input logic [3:0] r);
    logic [31:0] target;
    logic [31:0] skipAt;
    target = modelPc + 12;
    skipAt = target - 4;
    addInstr(op, 4'd0, 4'd0, r, target);
    if (modelPc == target) ramWord[skipAt[13:2]] = encode(cpu_pkg::DoutR, 4'd15, 4'd0, 4'd0);
    else addInstr(cpu_pkg::DoutR, 4'd15, 4'd0, 4'd0, '0);
  endtask

  task automatic aluCheck(input cpu_pkg::opcode_t op);
    logic [3:0]  a;
    logic [3:0]  b;
    logic [3:0]  d;
    logic [31:0] k1;
    logic [31:0] k2;
    logic [31:0] k3;
    pickReg(a);
    pickReg(b);
    pickReg(d);
    randomBits(32, k1);
    randomBits((op == cpu_pkg::ShlRRR || op == cpu_pkg::ShrRRR) ? 5 : 32, k2); // Short shifts
    randomBits(32, k3);
    addInstr(cpu_pkg::MovRC, a, 4'd0, 4'd0, k1);
    addInstr(cpu_pkg::MovRC, b, 4'd0, 4'd0, k2);
    addInstr(op, d, a, b, k3);
    addInstr(cpu_pkg::DoutR, d, 4'd0, 4'd0, '0);
  endtask

  task automatic memCheck();
    logic [3:0]  a;
    logic [3:0]  d;
    logic [3:0]  p;
    logic [31:0] addr;
    logic [31:0] v;
    pickReg(a);
    pickReg(d);
    pickReg(p);
    randomBits(8, addr);
    addr = 32'h2000 + (addr << 2); // Data area above the program
    randomBits(32, v);
    addInstr(cpu_pkg::MovRC, a, 4'd0, 4'd0, v);
    addInstr(cpu_pkg::MovdCR, 4'd0, a, 4'd0, addr);
    addInstr(cpu_pkg::MovRdC, d, 4'd0, 4'd0, addr);
    addInstr(cpu_pkg::DoutR, d, 4'd0, 4'd0, '0);
    addInstr(cpu_pkg::DecR, d, 4'd0, 4'd0, '0);
    addInstr(cpu_pkg::MovRC, p, 4'd0, 4'd0, addr);
    addInstr(cpu_pkg::MovRdR, d, p, 4'd0, '0);
    addInstr(cpu_pkg::DoutR, d, 4'd0, 4'd0, '0);
  endtask

  task automatic stackCheck();
    logic [3:0]  a;
    logic [3:0]  d;
    logic [3:0]  t;
    logic [31:0] v;
    logic [31:0] sub;
    pickReg(a);
    pickReg(d);
    pickReg(t);
    randomBits(32, v);
    addInstr(cpu_pkg::MovRC, a, 4'd0, 4'd0, v);
    addInstr(cpu_pkg::PushR, a, 4'd0, 4'd0, '0);
    addInstr(cpu_pkg::PopR, d, 4'd0, 4'd0, '0);
    addInstr(cpu_pkg::DoutR, d, 4'd0, 4'd0, '0);
    // Call at pc+8 with the JmpC after it and the subroutine behind the JmpC
    sub = modelPc + 8 + 12;
    addInstr(cpu_pkg::MovRC, t, 4'd0, 4'd0, sub);
    addInstr(cpu_pkg::CallR, t, 4'd0, 4'd0, '0);
    addInstr(cpu_pkg::DoutR, a, 4'd0, 4'd0, '0);
    addInstr(cpu_pkg::Ret, 4'd0, 4'd0, 4'd0, '0);
    addInstr(cpu_pkg::JmpC, 4'd0, 4'd0, 4'd0, sub + 8);
  endtask

  task automatic compareCheck();
    logic [3:0]  x;
    logic [3:0]  y;
    logic [3:0]  d;
    logic [31:0] v;
    logic [31:0] w;
    pickReg(x);
    y = (x == 4'd14) ? 4'd3 : x + 4'd1; // Distinct from x
    d = (y == 4'd14) ? 4'd3 : y + 4'd1;
    randomBits(32, v);
    randomBits(32, w);
    addInstr(cpu_pkg::MovRC, x, 4'd0, 4'd0, v);
    addInstr(cpu_pkg::MovRR, y, x, 4'd0, '0);
    addInstr(cpu_pkg::CmpRR, x, y, 4'd0, '0); // Equal
    addInstr(cpu_pkg::DoutR, 4'(`FLAG_REG), 4'd0, 4'd0, '0);
    condJump(cpu_pkg::JeC, 4'd0);
    condJump(cpu_pkg::JneC, 4'd0);
    addInstr(cpu_pkg::MovRC, y, 4'd0, 4'd0, w);
    addInstr(cpu_pkg::CmpRR, x, y, 4'd0, '0); // Less or greater
    addInstr(cpu_pkg::DoutR, 4'(`FLAG_REG), 4'd0, 4'd0, '0);
    condJump(cpu_pkg::JeC, 4'd0);
    condJump(cpu_pkg::JneC, 4'd0);
    addInstr(cpu_pkg::CmpLtRRR, d, x, y, '0);
    addInstr(cpu_pkg::DoutR, d, 4'd0, 4'd0, '0);
    condJump(cpu_pkg::JzRC, d);
    addInstr(cpu_pkg::CmpLtRRR, d, y, x, '0); // Opposite order
    addInstr(cpu_pkg::DoutR, d, 4'd0, 4'd0, '0);
    condJump(cpu_pkg::JzRC, d);
  endtask

  task automatic buildProgram();
    logic [31:0] marker;
    modelPc  = '0;
    busCycle = 32'd2; // Boot state, then first fetch
    for (int i = 0; i < `REG_COUNT; i++) modelRegs[i] = '0;
    randomBits(32, marker);
    addInstr(cpu_pkg::MovRC, 4'(`SP_REG), 4'd0, 4'd0, 32'h3000); // Stack clear of code
    addInstr(cpu_pkg::MovRC, 4'd15, 4'd0, 4'd0, marker);
    addInstr(cpu_pkg::DoutR, 4'd15, 4'd0, 4'd0, '0);
    for (int round = 0; round < 2; round++) begin
      aluCheck(cpu_pkg::MovRR);
      aluCheck(cpu_pkg::AddRRR);
      aluCheck(cpu_pkg::AddRRC);
      aluCheck(cpu_pkg::SubRRR);
      aluCheck(cpu_pkg::IncR);
      aluCheck(cpu_pkg::DecR);
      aluCheck(cpu_pkg::ShlRRR);
      aluCheck(cpu_pkg::ShrRRR);
      memCheck();
    end
    stackCheck();
    compareCheck();
    for (int i = 0; i < 3; i++) addInstr(cpu_pkg::Stall, 4'd0, 4'd0, 4'd0, '0);
  endtask

  task automatic checkBus();
    busEvent_t ev;
    if (busQueue.size() == 0) begin
      abortRun($sformatf("RAM request at %0t ns with no transfer expected", $time));
    end else begin
      ev = busQueue.pop_front();
      assert (ev.cycle == edgeCount) else reportMismatch("request cycle", ev.cycle, edgeCount);
      assert (ev.write == writeReq) else reportMismatch("writeReq", 32'(ev.write), 32'(writeReq));
      assert (ev.address == ramAddress) else reportMismatch("ramAddress", ev.address, ramAddress);
      if (ev.write) begin
        assert (ev.data == ramOut) else reportMismatch("ramOut", ev.data, ramOut);
      end
    end
  endtask

  task automatic checkDout();
    logic [31:0] expected;
    logic [31:0] expectedPointer;
    if (doutQueue.size() == 0) begin
      abortRun($sformatf("doutStrobe at %0t ns with no value expected", $time));
    end else begin
      expected        = doutQueue.pop_front();
      expectedPointer = pointerQueue.pop_front();
      assert (expected == doutValue) else reportMismatch("doutValue", expected, doutValue);
      assert (expectedPointer == instrPointer)
        else reportMismatch("instrPointer", expectedPointer, instrPointer);
    end
  endtask

  // RAM model and bus checks with read data from the next edge on
  always @(posedge clk) begin
    if (!reset) edgeCount++;
    sampledRead  = readReq;
    sampledWrite = writeReq;
    sampledAddr  = ramAddress;
    sampledData  = ramOut;
    if (readReq || writeReq) checkBus();
    if (doutStrobe) checkDout();
    #1;
    if (sampledWrite) ramWord[sampledAddr[13:2]] = sampledData;
    if (pendingRead) ramIn = ramWord[pendingAddr[13:2]];
    pendingRead = sampledRead;
    pendingAddr = sampledAddr;
  end

  initial begin
    for (int i = 0; i < ramWords; i++) ramWord[i] = 32'h5a000000 | (i << 2); // Byte address fill
    lfsrState = 32'h22e2;
    buildProgram();
    programBuilt = 1'b1;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    while (busQueue.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    if (doutQueue.size() != 0) begin
      abortRun("program ended with doutValue results still pending");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

  // At most 10 cycles per instruction plus reset and margin
  initial begin
    int limit;
    wait (programBuilt);
    limit = instrCount * 10 * clockPeriod + 2000;
    #(limit);
    abortRun("timeout, program did not reach its final Stall");
  end

endmodule

//--- build.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/fetchStage.sv
verilog/regFile.sv
verilog/memStage.sv
verilog/execStage.sv
verilog/cpuCore.sv
test/cpuCore_assert.sv
test/cpuCore_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cpuCore testbench, exit status reflects the result
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module cpuCore_tb -f build.f -o simv \
  && ./obj_dir/simv \
  || exit 1
